/* Bender.yml */
package:
  name: id_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/id_pkg.sv
      - rtl/id_illegal_check.sv
      - rtl/id_operand_sel.sv
      - rtl/id_hazard_unit.sv
      - rtl/id_stage.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/id_tb_clk.sv
      - verif/id_stage_sva.sv
      - verif/id_tb.sv

/* rtl/id_cfg.svh */
/*
 * Build-time configuration of the decode stage.
 * Included by the package and by any module that needs a width, the reset pc or a cause bit.
 */

`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// Data and pc width
`define ID_XLEN 32

// Exception cause vector width
`define ID_EXC_W 16

// Pc after reset
`define ID_PC_INIT 32'h0000_0200

// Cause bit positions in the exception vector
`define ID_CAUSE_ILLEGAL 2
`define ID_CAUSE_BREAK   3
`define ID_CAUSE_UECALL  8
`define ID_CAUSE_MECALL  11

`endif

/* rtl/id_hazard_unit.sv */
/*
 * Registered bypass selects for the ex, mem and wb forwarding paths.
 * Combinational load-use stall against the decode and ex stages.
 */

`timescale 1ns/1ps

module id_hazard_unit (
  input  logic           clk,
  input  logic           stall,
  input  logic           flush,
  input  id_pkg::instr_t if_instr,
  input  logic           if_bubble,
  input  id_pkg::stage_t id_stage_info,
  input  id_pkg::stage_t ex_stage,
  input  id_pkg::stage_t mem_stage,
  output logic           bypex_a,
  output logic           bypmem_a,
  output logic           bypwb_a,
  output logic           bypex_b,
  output logic           bypmem_b,
  output logic           bypwb_b,
  output logic           id_stall
);

  import id_pkg::*;

  opcode_t   if_opcode;
  reg_addr_t if_src1;
  reg_addr_t if_src2;
  reg_addr_t id_dst;
  reg_addr_t ex_dst;
  logic      use_a;
  logic      use_b;
  logic      ld_dep_id;
  logic      ld_dep_ex;

  // x0 is a sink, a zero destination never forwards
  function automatic logic hit(reg_addr_t src, stage_t s);
    return (src == s.instr[11:7]) && (s.instr[11:7] != '0) && writes_rd(s);
  endfunction

  assign if_opcode = if_instr[6:2];
  assign if_src1   = if_instr[19:15];
  assign if_src2   = if_instr[24:20];
  assign use_a     = uses_rs1(if_opcode);
  assign use_b     = uses_rs2(if_opcode);

  ////////////////////////////////////////
  // Bypass selects
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!stall) begin
      bypex_a  <= use_a & hit(if_src1, id_stage_info);
      bypmem_a <= use_a & hit(if_src1, ex_stage);
      bypwb_a  <= use_a & hit(if_src1, mem_stage);
      bypex_b  <= use_b & hit(if_src2, id_stage_info);
      bypmem_b <= use_b & hit(if_src2, ex_stage);
      bypwb_b  <= use_b & hit(if_src2, mem_stage);
    end
  end

  ////////////////////////////////////////
  // Load-use stall
  ////////////////////////////////////////
  assign id_dst = id_stage_info.instr[11:7];
  assign ex_dst = ex_stage.instr[11:7];

  // Load data is not ready until it leaves mem
  assign ld_dep_id = (id_stage_info.instr[6:2] == OPC_LOAD) && !id_stage_info.bubble &&
                     ((use_a && (if_src1 == id_dst)) || (use_b && (if_src2 == id_dst)));
  assign ld_dep_ex = (ex_stage.instr[6:2] == OPC_LOAD) && !ex_stage.bubble &&
                     ((use_a && (if_src1 == ex_dst)) || (use_b && (if_src2 == ex_dst)));

  always_comb begin
    if (flush)      id_stall = 1'b0;        // Flush overrules stall
    else if (stall) id_stall = ~if_bubble;  // Fetch bubbles need no hold
    else            id_stall = ld_dep_id | ld_dep_ex;
  end

endmodule

/* rtl/id_illegal_check.sv */
/*
 * Classifies the fetched word against the RV32I base set.
 * Flags illegal, breakpoint and environment call for the decode exception register.
 */

`timescale 1ns/1ps

module id_illegal_check (
  input  id_pkg::instr_t if_instr,
  input  id_pkg::prv_t   st_prv,
  output logic [2:0]     exc_kind    // {illegal, breakpoint, ecall}
);

  import id_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_ecall;
  logic       is_ebreak;
  logic       is_mret;
  logic       illegal;

  assign opcode    = if_instr[6:2];
  assign funct3    = if_instr[14:12];
  assign funct7    = if_instr[31:25];
  assign is_ecall  = (if_instr == INSTR_ECALL);
  assign is_ebreak = (if_instr == INSTR_EBREAK);
  assign is_mret   = (if_instr == INSTR_MRET);

  always_comb begin
    illegal = 1'b0;
    case (opcode)
      OPC_LUI, OPC_AUIPC, OPC_JAL: illegal = 1'b0;
      OPC_JALR:     illegal = (funct3 != 3'b000);
      OPC_BRANCH:   illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
      OPC_LOAD:     illegal = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
      OPC_STORE:    illegal = funct3[2] || (funct3 == 3'b011);
      OPC_MISC_MEM: illegal = (funct3[2:1] != 2'b00);  // FENCE and FENCE.I only
      OPC_OP_IMM: begin
        case (funct3)
          3'b001:  illegal = (funct7[6:1] != 6'b0) || funct7[0];
          3'b101:  illegal = ((funct7[6:1] != 6'b0) && (funct7[6:1] != 6'b010000)) ||
                             funct7[0];  // shamt[5] not valid on RV32
          default: illegal = 1'b0;
        endcase
      end
      OPC_OP: begin
        illegal = !((funct7 == 7'b0000000) ||
                    ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101))));
      end
      OPC_SYSTEM: begin
        // CSR accesses pass, no permission table here
        if (funct3 == 3'b000) illegal = !(is_ecall || is_ebreak || (is_mret && st_prv == PRV_M));
        else                  illegal = (funct3 == 3'b100);
      end
      default: illegal = 1'b1;
    endcase
    if (if_instr[1:0] != 2'b11) illegal = 1'b1;  // Compressed space
  end

  assign exc_kind = {illegal, is_ebreak, is_ecall};

endmodule

/* rtl/id_operand_sel.sv */
/*
 * Immediate generation and operand A/B registers for the execute stage.
 * Also registers the register-file-use flags, cleared when writeback already has the source.
 */

`timescale 1ns/1ps

module id_operand_sel (
  input  logic           clk,
  input  id_pkg::instr_t if_instr,
  input  id_pkg::xlen_t  if_pc,
  input  id_pkg::xlen_t  wb_r,
  input  id_pkg::stage_t wb_stage,
  input  logic           stall,
  output id_pkg::xlen_t  id_opa,
  output id_pkg::xlen_t  id_opb,
  output logic           userf_a,
  output logic           userf_b
);

  import id_pkg::*;

  opcode_t   opcode;
  reg_addr_t if_src1;
  reg_addr_t if_src2;
  reg_addr_t wb_dst;
  xlen_t     imm_i;
  xlen_t     imm_u;
  logic      can_ldwb;
  logic      wb_hit_a;
  logic      wb_hit_b;

  assign opcode  = if_instr[6:2];
  assign if_src1 = if_instr[19:15];
  assign if_src2 = if_instr[24:20];
  assign wb_dst  = wb_stage.instr[11:7];

  ////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////
  assign imm_i = xlen_t'($signed(if_instr[31:20]));
  assign imm_u = xlen_t'($signed({if_instr[31:12], 12'h000}));

  // Writeback result lands between wb_r and the register file
  assign can_ldwb = writes_rd(wb_stage);
  assign wb_hit_a = (if_src1 == wb_dst) && (wb_dst != '0) && can_ldwb;
  assign wb_hit_b = (if_src2 == wb_dst) && (wb_dst != '0) && can_ldwb;

  always_ff @(posedge clk) begin
    if (!stall) begin
      userf_a <= uses_rs1(opcode) & ~wb_hit_a;
      userf_b <= uses_rs2(opcode) & ~wb_hit_b;
    end
  end

  ////////////////////////////////////////
  // Operand registers
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!stall) begin
      case (opcode)
        OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
          id_opa <= wb_r;
          id_opb <= imm_i;
        end
        OPC_OP, OPC_BRANCH, OPC_STORE: begin
          id_opa <= wb_r;
          id_opb <= wb_r;
        end
        OPC_AUIPC: begin
          id_opa <= if_pc;
          id_opb <= imm_u;
        end
        OPC_LUI: begin
          id_opa <= '0;
          id_opb <= imm_u;
        end
        OPC_SYSTEM: begin
          id_opa <= wb_r;              // CSR source register
          id_opb <= xlen_t'(if_src1);  // Zero-extended uimm for CSRxxI
        end
        default: ;  // JAL, FENCE and illegal words leave operands as they are
      endcase
    end
  end

endmodule

/* rtl/id_pkg.sv */
/*
 * Shared types, opcode and privilege constants for the decode stage.
 * Modules import it inside their body and use scoped names in their ports.
 */

`include "id_cfg.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0]  xlen_t;
  typedef logic [31:0]          instr_t;
  typedef logic [4:0]           reg_addr_t;
  typedef logic [4:0]           opcode_t;    // Instruction bits 6:2
  typedef logic [`ID_EXC_W-1:0] exc_t;
  typedef logic [1:0]           prv_t;

  ////////////////////////////////////////
  // Base opcodes
  ////////////////////////////////////////
  localparam opcode_t OPC_LOAD     = 5'b00000;
  localparam opcode_t OPC_MISC_MEM = 5'b00011;
  localparam opcode_t OPC_OP_IMM   = 5'b00100;
  localparam opcode_t OPC_AUIPC    = 5'b00101;
  localparam opcode_t OPC_STORE    = 5'b01000;
  localparam opcode_t OPC_OP       = 5'b01100;
  localparam opcode_t OPC_LUI      = 5'b01101;
  localparam opcode_t OPC_BRANCH   = 5'b11000;
  localparam opcode_t OPC_JALR     = 5'b11001;
  localparam opcode_t OPC_JAL      = 5'b11011;
  localparam opcode_t OPC_SYSTEM   = 5'b11100;

  localparam prv_t PRV_U = 2'b00;
  localparam prv_t PRV_M = 2'b11;

  // Full encodings of the fixed SYSTEM instructions
  localparam instr_t INSTR_ECALL  = 32'h0000_0073;
  localparam instr_t INSTR_EBREAK = 32'h0010_0073;
  localparam instr_t INSTR_MRET   = 32'h3020_0073;

  // One later pipeline stage, as seen from decode
  typedef struct packed {
    instr_t instr;
    logic   bubble;
  } stage_t;

  // Source choice for one operand
  typedef struct packed {
    logic userf;
    logic bypex;
    logic bypmem;
    logic bypwb;
  } byp_t;

  // Stage holds a valid instruction that writes rd
  function automatic logic writes_rd(stage_t s);
    case (s.instr[6:2])
      OPC_LOAD, OPC_OP_IMM, OPC_AUIPC, OPC_OP, OPC_LUI,
      OPC_JALR, OPC_JAL, OPC_SYSTEM: return ~s.bubble;
      default:                       return 1'b0;
    endcase
  endfunction

  function automatic logic uses_rs1(opcode_t opc);
    return opc inside {OPC_OP_IMM, OPC_OP, OPC_BRANCH, OPC_JALR,
                       OPC_LOAD, OPC_STORE, OPC_SYSTEM};
  endfunction

  function automatic logic uses_rs2(opcode_t opc);
    return opc inside {OPC_OP, OPC_BRANCH, OPC_STORE};
  endfunction

endpackage

/* rtl/id_stage.sv */
/*
 * Instruction decode stage of the RV32I pipeline.
 * Holds the pc, instruction, bubble and exception registers and ties the decode helpers together.
 */

`timescale 1ns/1ps

`include "id_cfg.svh"

module id_stage (
  input  logic           clk,
  input  logic           rstn,
  // Fetch
  input  id_pkg::xlen_t  if_pc,
  input  id_pkg::instr_t if_instr,
  input  logic           if_bubble,
  input  id_pkg::exc_t   if_exception,
  // Pipeline control
  input  logic           ex_stall,
  input  logic           bu_flush,
  input  id_pkg::xlen_t  bu_nxt_pc,
  input  logic           st_flush,
  input  id_pkg::xlen_t  st_nxt_pc,
  input  id_pkg::prv_t   st_prv,
  // Later stages
  input  id_pkg::stage_t ex_stage,
  input  id_pkg::stage_t mem_stage,
  input  id_pkg::stage_t wb_stage,
  input  id_pkg::xlen_t  wb_r,
  // To execute
  output id_pkg::xlen_t  id_pc,
  output id_pkg::instr_t id_instr,
  output logic           id_bubble,
  output id_pkg::exc_t   id_exception,
  output logic           id_stall,
  output id_pkg::reg_addr_t id_src1,
  output id_pkg::reg_addr_t id_src2,
  output id_pkg::xlen_t  id_opa,
  output id_pkg::xlen_t  id_opb,
  output id_pkg::byp_t   byp_a,
  output id_pkg::byp_t   byp_b
);

  import id_pkg::*;

  logic       stall;
  logic       flush;
  logic       id_bubble_r;
  logic [2:0] exc_kind;
  exc_t       dec_exc;
  stage_t     id_stage_info;
  logic       userf_a, userf_b;
  logic       bypex_a, bypmem_a, bypwb_a;
  logic       bypex_b, bypmem_b, bypwb_b;

  assign stall = ex_stall;  // Local stall
  assign flush = bu_flush | st_flush;

  ////////////////////////////////////////
  // Pipeline registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)                    id_pc <= xlen_t'(`ID_PC_INIT);
    else if (st_flush)            id_pc <= st_nxt_pc;
    else if (bu_flush)            id_pc <= bu_nxt_pc;
    else if (!stall && !id_stall) id_pc <= if_pc;
  end

  always_ff @(posedge clk) begin
    if (!stall) id_instr <= if_instr;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)       id_bubble_r <= 1'b1;
    else if (flush)  id_bubble_r <= 1'b1;
    else if (!stall) id_bubble_r <= id_stall | if_bubble;  // Load-use inserts a bubble
  end

  assign id_bubble     = stall | flush | id_bubble_r;
  assign id_stage_info = '{instr: id_instr, bubble: id_bubble_r};

  // Decoded causes are only valid for a real fetch
  always_comb begin
    dec_exc                    = if_exception;
    dec_exc[`ID_CAUSE_ILLEGAL] = ~if_bubble & exc_kind[2];
    dec_exc[`ID_CAUSE_BREAK]   = ~if_bubble & exc_kind[1];
    dec_exc[`ID_CAUSE_UECALL]  = ~if_bubble & exc_kind[0] & (st_prv == PRV_U);
    dec_exc[`ID_CAUSE_MECALL]  = ~if_bubble & exc_kind[0] & (st_prv == PRV_M);
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)        id_exception <= '0;
    else if (flush)   id_exception <= '0;
    else if (!stall) begin
      if (id_stall) id_exception <= '0;
      else          id_exception <= dec_exc;
    end
  end

  // Register file addresses, held with the pipeline
  assign id_src1 = stall ? id_instr[19:15] : if_instr[19:15];
  assign id_src2 = stall ? id_instr[24:20] : if_instr[24:20];

  ////////////////////////////////////////
  // Decode helpers
  ////////////////////////////////////////
  id_illegal_check u_illegal (
    .if_instr (if_instr),
    .st_prv   (st_prv),
    .exc_kind (exc_kind)
  );

  id_operand_sel u_operand (
    .clk      (clk),
    .if_instr (if_instr),
    .if_pc    (if_pc),
    .wb_r     (wb_r),
    .wb_stage (wb_stage),
    .stall    (stall),
    .id_opa   (id_opa),
    .id_opb   (id_opb),
    .userf_a  (userf_a),
    .userf_b  (userf_b)
  );

  id_hazard_unit u_hazard (
    .clk           (clk),
    .stall         (stall),
    .flush         (flush),
    .if_instr      (if_instr),
    .if_bubble     (if_bubble),
    .id_stage_info (id_stage_info),
    .ex_stage      (ex_stage),
    .mem_stage     (mem_stage),
    .bypex_a       (bypex_a),
    .bypmem_a      (bypmem_a),
    .bypwb_a       (bypwb_a),
    .bypex_b       (bypex_b),
    .bypmem_b      (bypmem_b),
    .bypwb_b       (bypwb_b),
    .id_stall      (id_stall)
  );

  assign byp_a = '{userf: userf_a, bypex: bypex_a, bypmem: bypmem_a, bypwb: bypwb_a};
  assign byp_b = '{userf: userf_b, bypex: bypex_b, bypmem: bypmem_b, bypwb: bypwb_b};

endmodule

/* sources.f */
+incdir+rtl
rtl/id_pkg.sv
rtl/id_illegal_check.sv
rtl/id_operand_sel.sv
rtl/id_hazard_unit.sv
rtl/id_stage.sv
verif/id_tb_clk.sv
verif/id_stage_sva.sv
verif/id_tb.sv

/* verif/id_stage_sva.sv */
/*
 * Concurrent checks on flush, stall and reset behavior of the decode stage.
 * Attached to every id_stage instance by the bind at the end.
 */

`timescale 1ns/1ps

`include "id_cfg.svh"

module id_stage_sva (
  input logic          clk,
  input logic          rstn,
  input logic          ex_stall,
  input logic          bu_flush,
  input logic          st_flush,
  input id_pkg::xlen_t st_nxt_pc,
  input logic          id_stall,
  input logic          id_bubble,
  input id_pkg::xlen_t id_pc,
  input id_pkg::exc_t  id_exception
);

  import id_pkg::*;

  logic        flush;
  int unsigned fail_cnt = 0;

  assign flush = bu_flush | st_flush;

  a_flush_no_stall: assert property (@(posedge clk) disable iff (!rstn)
    flush |-> !id_stall)
    else begin
      $error("stall raised during a flush");
      fail_cnt++;
    end

  a_flush_clears_exc: assert property (@(posedge clk) disable iff (!rstn)
    flush |=> (id_exception == '0))
    else begin
      $error("exception survived a flush");
      fail_cnt++;
    end

  a_st_flush_pc: assert property (@(posedge clk) disable iff (!rstn)
    st_flush |=> (id_pc == $past(st_nxt_pc)))
    else begin
      $error("pc not redirected by st_flush");
      fail_cnt++;
    end

  // Back-pressure freezes the registered outputs
  a_stall_hold: assert property (@(posedge clk) disable iff (!rstn)
    (ex_stall && !flush) |=> ($stable(id_pc) && $stable(id_exception)))
    else begin
      $error("registers moved under ex_stall");
      fail_cnt++;
    end

  a_bubble_level: assert property (@(posedge clk) disable iff (!rstn)
    (flush || ex_stall) |-> id_bubble)
    else begin
      $error("bubble low under stall or flush");
      fail_cnt++;
    end

  a_reset_values: assert property (@(posedge clk)
    $rose(rstn) |-> (id_bubble && (id_exception == '0) && (id_pc == xlen_t'(`ID_PC_INIT))))
    else begin
      $error("wrong values after reset");
      fail_cnt++;
    end

endmodule

bind id_stage id_stage_sva u_sva (.*);

/* verif/id_tb.sv */
/*
 * Table-driven testbench for the decode stage.
 * Each row is driven on the falling edge and checked after the next rising edge.
 */

`timescale 1ns/1ps

`include "id_cfg.svh"

module id_tb;

  import id_pkg::*;

  // Row control bits {st_flush, bu_flush, ex_stall, if_bubble}
  localparam logic [3:0] C_NONE  = 4'b0000;
  localparam logic [3:0] C_ST    = 4'b1100;  // Both flushes with st winning
  localparam logic [3:0] C_BU    = 4'b0100;
  localparam logic [3:0] C_HOLD  = 4'b0010;
  localparam logic [3:0] C_HOLDB = 4'b0011;
  localparam logic [3:0] C_FBUB  = 4'b0001;
  localparam logic [1:0] S_ZERO = 2'd0;  // Operand A source
  localparam logic [1:0] S_WB   = 2'd1;
  localparam logic [1:0] S_PC   = 2'd2;
  localparam logic [1:0] S_RR   = 2'd3;  // wb_r on both operands
  localparam instr_t NOP = 32'h0000_0013;

  typedef struct {
    string     name;
    instr_t    instr;
    logic [3:0] ctl;
    prv_t      prv;
    exc_t      exc_in;
    stage_t    ex_s, mem_s, wb_s;
    logic      exp_stall;
    reg_addr_t exp_src1;
    logic      exp_bub;
    exc_t      exp_exc;
    logic [1:0] opa_sel;
    xlen_t     opb;
    logic [1:0] chk;  // {operands, bypass}
    byp_t      ba, bb;
    xlen_t     pc, npc, wbr;
  } row_t;

  logic clk, rstn;
  xlen_t if_pc, bu_nxt_pc, st_nxt_pc, wb_r;
  instr_t if_instr;
  logic if_bubble, ex_stall, bu_flush, st_flush;
  exc_t if_exception;
  prv_t st_prv;
  stage_t ex_stage, mem_stage, wb_stage;
  xlen_t id_pc, id_opa, id_opb;
  instr_t id_instr;
  logic id_bubble, id_stall;
  exc_t id_exception;
  reg_addr_t id_src1, id_src2;
  byp_t byp_a, byp_b;

  row_t tbl[$];
  logic [31:0] rng = 32'd81272;
  int errors = 0;
  int checks = 0;

  id_tb_clk u_clk (.clk(clk), .rstn(rstn));

  id_stage u_dut (.*);

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  ////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////
  function automatic instr_t enc_i(logic [6:0] opc, reg_addr_t rd, logic [2:0] f3,
                                   reg_addr_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_r(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    return {7'b0, rs2, rs1, 3'b000, rd, 7'h33};  // ADD
  endfunction

  function automatic instr_t enc_u(logic [6:0] opc, reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic stage_t stg(instr_t i, logic bub);
    return '{instr: i, bubble: bub};
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_word(string name, xlen_t exp, xlen_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_instr(string name, instr_t exp, instr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_exc(string name, exc_t exp, exc_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_byp(string name, byp_t exp, byp_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic add_row(string name, instr_t instr, logic [3:0] ctl, prv_t prv, exc_t exc_in,
                         stage_t ex_s, stage_t mem_s, stage_t wb_s, logic exp_stall,
                         reg_addr_t exp_src1, logic exp_bub, exc_t exp_exc,
                         logic [1:0] opa_sel, xlen_t opb, logic [1:0] chk, byp_t ba, byp_t bb);
    row_t r;
    r = '{name, instr, ctl, prv, exc_in, ex_s, mem_s, wb_s, exp_stall, exp_src1, exp_bub,
          exp_exc, opa_sel, opb, chk, ba, bb, xorshift(), xorshift(), xorshift()};
    tbl.push_back(r);
  endtask

  task automatic build_table();
    stage_t b;
    b = stg(NOP, 1'b1);
    // Operand and bypass rows with byp as {userf, bypex, bypmem, bypwb}
    add_row("addi", enc_i(7'h13, 5, 0, 1, 12'hffd), C_NONE, PRV_M, 0, b, b, b,
            0, 1, 0, 0, S_WB, 32'hffff_fffd, 2'b11, 4'b1000, 4'b0000);
    add_row("byp_ex", enc_r(6, 5, 2), C_NONE, PRV_M, 0, b, b, b,
            0, 5, 0, 0, S_RR, 0, 2'b11, 4'b1100, 4'b1000);
    add_row("byp_mem_wb", enc_r(7, 3, 4), C_NONE, PRV_M, 0, stg(enc_i(7'h13, 3, 0, 0, 0), 0),
            stg(enc_i(7'h13, 4, 0, 0, 1), 0), b, 0, 3, 0, 0, S_WB, 0, 2'b01, 4'b1010, 4'b1001);
    add_row("byp_x0", enc_r(8, 0, 0), C_NONE, PRV_M, 0, stg(enc_i(7'h13, 0, 0, 1, 0), 0),
            stg(enc_i(7'h13, 0, 0, 2, 0), 0), b, 0, 0, 0, 0, S_WB, 0, 2'b01, 4'b1000, 4'b1000);
    add_row("byp_bubble", enc_r(9, 10, 11), C_NONE, PRV_M, 0, stg(enc_i(7'h13, 10, 0, 0, 0), 1),
            stg(enc_i(7'h13, 11, 0, 0, 0), 1), stg(enc_r(10, 1, 2), 0),
            0, 10, 0, 0, S_WB, 0, 2'b01, 4'b0000, 4'b1000);
    add_row("lui", enc_u(7'h37, 12, 20'habcde), C_NONE, PRV_M, 0, b, b, b,
            0, 5'h1b, 0, 0, S_ZERO, 32'habcd_e000, 2'b11, 4'b0000, 4'b0000);
    add_row("auipc", enc_u(7'h17, 13, 20'h12345), C_NONE, PRV_M, 0, b, b, b,
            0, 5'h08, 0, 0, S_PC, 32'h1234_5000, 2'b11, 4'b0000, 4'b0000);
    // Load-use against decode and then against ex
    add_row("load", enc_i(7'h03, 14, 3'b010, 1, 12'd4), C_NONE, PRV_M, 0, b, b, b,
            0, 1, 0, 0, S_WB, 4, 2'b11, 4'b1000, 4'b0000);
    add_row("load_use_id", enc_i(7'h13, 15, 0, 14, 1), C_NONE, PRV_M, 0, b, b, b,
            1, 14, 1, 0, S_WB, 1, 2'b00, 0, 0);
    add_row("after_stall", enc_i(7'h13, 15, 0, 14, 1), C_NONE, PRV_M, 0, b, b, b,
            0, 14, 0, 0, S_WB, 1, 2'b11, 4'b1000, 4'b0000);
    add_row("load_use_ex", enc_r(16, 17, 18), C_NONE, PRV_M, 0,
            stg(enc_i(7'h03, 18, 3'b010, 1, 0), 0), b, b, 1, 17, 1, 0, S_WB, 0, 2'b00, 0, 0);
    // Exceptions
    add_row("illegal", 32'h0000_005b, C_NONE, PRV_M, 0, b, b, b,
            0, 0, 0, 16'h0004, S_WB, 0, 2'b01, 4'b0000, 4'b0000);
    add_row("ebreak", 32'h0010_0073, C_NONE, PRV_M, 0, b, b, b,
            0, 0, 0, 16'h0008, S_WB, 0, 2'b11, 4'b1000, 4'b0000);
    add_row("ecall_m", 32'h0000_0073, C_NONE, PRV_M, 0, b, b, b,
            0, 0, 0, 16'h0800, S_WB, 0, 2'b11, 4'b1000, 4'b0000);
    add_row("ecall_u", 32'h0000_0073, C_NONE, PRV_U, 0, b, b, b,
            0, 0, 0, 16'h0100, S_WB, 0, 2'b11, 4'b1000, 4'b0000);
    add_row("mret_u", 32'h3020_0073, C_NONE, PRV_U, 0, b, b, b,
            0, 0, 0, 16'h0004, S_WB, 0, 2'b00, 0, 0);
    add_row("bubble_fetch", 32'h0000_005b, C_FBUB, PRV_M, 16'h0001, b, b, b,
            0, 0, 1, 16'h0001, S_WB, 0, 2'b00, 0, 0);
    // Flushes and back-pressure
    add_row("flush_st", NOP, C_ST, PRV_M, 0, b, b, b, 0, 0, 1, 0, S_WB, 0, 2'b00, 0, 0);
    add_row("flush_bu", NOP, C_BU, PRV_M, 0, b, b, b, 0, 0, 1, 0, S_WB, 0, 2'b00, 0, 0);
    add_row("csrrw", enc_i(7'h73, 1, 3'b001, 21, 12'h300), C_NONE, PRV_M, 16'h0010, b, b, b,
            0, 21, 0, 16'h0010, S_WB, 21, 2'b11, 4'b1000, 4'b0000);
    add_row("hold", enc_u(7'h37, 22, 20'h01f55), C_HOLD, PRV_M, 0, b, b, b,
            1, 21, 1, 0, S_ZERO, 0, 2'b11, 0, 0);
    add_row("hold_bubble", enc_u(7'h37, 22, 20'h01f55), C_HOLDB, PRV_M, 0, b, b, b,
            0, 21, 1, 0, S_ZERO, 0, 2'b11, 0, 0);
    add_row("release", enc_u(7'h37, 23, 20'h00001), C_NONE, PRV_M, 0, b, b, b,
            0, 0, 0, 0, S_ZERO, 32'h0000_1000, 2'b11, 4'b0000, 4'b0000);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    row_t r;
    xlen_t exp_pc, exp_opa, exp_opb;
    xlen_t last_pc, last_opa, last_opb;
    exc_t exp_exc, last_exc;
    byp_t exp_ba, exp_bb, last_ba, last_bb;
    instr_t exp_instr, last_instr;
    reg_addr_t exp_src2;
    int sva_fails;

    if_pc = '0;
    if_instr = NOP;
    if_bubble = 1'b1;
    if_exception = '0;
    ex_stall = 1'b0;
    bu_flush = 1'b0;
    bu_nxt_pc = '0;
    st_flush = 1'b0;
    st_nxt_pc = '0;
    st_prv = PRV_M;
    ex_stage = stg(NOP, 1'b1);
    mem_stage = stg(NOP, 1'b1);
    wb_stage = stg(NOP, 1'b1);
    wb_r = '0;
    build_table();

    fork
      begin
        #((tbl.size() * 4 + 20) * 20);
        $display("Watchdog expired before the table finished");
        $display("Test failures found");
        $finish;
      end
    join_none

    wait (rstn === 1'b1);
    #1;
    check_bit("reset bubble", 1'b1, id_bubble);
    check_exc("reset exception", '0, id_exception);
    check_word("reset pc", xlen_t'(`ID_PC_INIT), id_pc);
    // Idle edge before the first row loads the resting fetch inputs
    last_pc = if_pc;
    last_exc = '0;
    last_instr = if_instr;

    foreach (tbl[i]) begin
      r = tbl[i];
      @(negedge clk);
      {st_flush, bu_flush, ex_stall, if_bubble} = r.ctl;
      if_instr = r.instr;
      if_pc = r.pc;
      if_exception = r.exc_in;
      st_prv = r.prv;
      st_nxt_pc = r.npc;
      bu_nxt_pc = ~r.npc;
      ex_stage = r.ex_s;
      mem_stage = r.mem_s;
      wb_stage = r.wb_s;
      wb_r = r.wbr;
      #1;
      exp_src2 = ex_stall ? last_instr[24:20] : r.instr[24:20];
      check_bit({r.name, " id_stall"}, r.exp_stall, id_stall);
      check_addr({r.name, " id_src1"}, r.exp_src1, id_src1);
      check_addr({r.name, " id_src2"}, exp_src2, id_src2);

      // Expected registered state from the pipeline rules
      if (st_flush)                    exp_pc = r.npc;
      else if (bu_flush)               exp_pc = ~r.npc;
      else if (ex_stall || r.exp_stall) exp_pc = last_pc;
      else                             exp_pc = r.pc;
      if (st_flush || bu_flush) exp_exc = '0;
      else if (ex_stall)        exp_exc = last_exc;
      else if (r.exp_stall)     exp_exc = '0;
      else                      exp_exc = r.exp_exc;
      if (ex_stall) exp_instr = last_instr;
      else          exp_instr = r.instr;
      if (ex_stall) begin
        exp_opa = last_opa;
        exp_opb = last_opb;
        exp_ba = last_ba;
        exp_bb = last_bb;
      end else begin
        exp_opa = (r.opa_sel == S_PC) ? r.pc : (r.opa_sel == S_ZERO) ? '0 : r.wbr;
        exp_opb = (r.opa_sel == S_RR) ? r.wbr : r.opb;
        exp_ba = r.ba;
        exp_bb = r.bb;
      end

      @(posedge clk);
      #1;
      check_word({r.name, " id_pc"}, exp_pc, id_pc);
      check_exc({r.name, " id_exception"}, exp_exc, id_exception);
      check_bit({r.name, " id_bubble"}, r.exp_bub, id_bubble);
      if (ex_stall || !r.exp_stall)
        check_instr({r.name, " id_instr"}, exp_instr, id_instr);
      if (r.chk[1]) begin
        check_word({r.name, " id_opa"}, exp_opa, id_opa);
        check_word({r.name, " id_opb"}, exp_opb, id_opb);
      end
      if (r.chk[0]) begin
        check_byp({r.name, " byp_a"}, exp_ba, byp_a);
        check_byp({r.name, " byp_b"}, exp_bb, byp_b);
      end
      last_pc = exp_pc;
      last_exc = exp_exc;
      last_instr = exp_instr;
      last_opa = exp_opa;
      last_opb = exp_opb;
      last_ba = exp_ba;
      last_bb = exp_bb;
    end

    sva_fails = u_dut.u_sva.fail_cnt;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* verif/id_tb_clk.sv */
/*
 * Clock and reset source for the decode stage testbench.
 * 20 ns period, rstn held low for the first 3 cycles.
 */

`timescale 1ns/1ps

module id_tb_clk (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rstn = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk) rstn = 1'b1;  // Release away from the active edge
  end

endmodule
